//--- common/allocPkg.sv
`default_nettype none

package allocPkg;

	// ----------------------------------------------------------------------
	// table geometry
	// ----------------------------------------------------------------------
	// banks scanned side by side
	localparam int NUM_BANKS_DEFAULT = 4;
	// entries held by one bank
	localparam int BANK_DEPTH_DEFAULT = 16;

	// selector and length of one cached object
	localparam int SEL_W = 24;
	localparam int LEN_W = 32;
	// running total of cached lengths
	localparam int SUM_W = 40;

	// one table slot, zero selector means the slot is free
	typedef struct packed {
		logic [SEL_W-1:0] selector;
		logic [LEN_W-1:0] length;
	} cacheEntry_t;

	// command codes written by the host
	typedef enum logic [2:0] {
		OP_WRITE     = 3'd0,
		OP_CLEAR     = 3'd1,
		OP_FIND_FREE = 3'd2,
		OP_FIND_FIT  = 3'd3,
		OP_CALC      = 3'd4
	} cacheOp_t;

	// ----------------------------------------------------------------------
	// register map, word addresses
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		REG_LENGTH         = 3'd0,
		REG_SELECTOR       = 3'd1,
		REG_INDEX          = 3'd2,
		REG_COMMAND        = 3'd3,
		REG_FOUND_LENGTH   = 3'd4,
		REG_FOUND_SELECTOR = 3'd5,
		REG_FOUND_INDEX    = 3'd6,
		REG_CACHED_SUM     = 3'd7
	} regAddr_t;

	// status word seen on command address reads
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_FOUND_BIT = 1;

endpackage

`default_nettype wire

//--- common/cacheIfs.sv
`timescale 1ns/1ps
`default_nettype none

// broadcast from the dispatcher to every bank
interface scanIf import allocPkg::*; #(
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
);
	localparam int IDX_W = $clog2(BANK_DEPTH);
	localparam int BANK_W = $clog2(NUM_BANKS);

	cacheOp_t op;
	// one local index per cycle
	logic stepValid;
	logic [IDX_W-1:0] stepIndex;
	// entry write, also used for the clear sweep
	logic wrEn;
	logic [BANK_W-1:0] wrBank;
	cacheEntry_t wrData;
	logic [LEN_W-1:0] reqLength;
	// early end of a find scan
	logic stop;

	modport master (output op, stepValid, stepIndex, wrEn, wrBank, wrData, reqLength,
		input stop);
	modport bank (input op, stepValid, stepIndex, wrEn, wrBank, wrData, reqLength);
	modport collector (input wrEn, output stop);
endinterface

// one per bank, bank result toward the collector
interface bankHitIf import allocPkg::*; #(
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
);
	localparam int IDX_W = $clog2(BANK_DEPTH);

	logic hitValid;
	logic hit;
	logic [IDX_W-1:0] hitIndex;
	cacheEntry_t entry;

	modport source (output hitValid, hit, hitIndex, entry);
	modport sink (input hitValid, hit, hitIndex, entry);
endinterface

// command request and result path
interface resultIf import allocPkg::*; #(
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
);
	localparam int GIDX_W = $clog2(NUM_BANKS * BANK_DEPTH);

	// request side, from the register file
	logic start;
	cacheOp_t op;
	logic [LEN_W-1:0] length;
	logic [SEL_W-1:0] selector;
	logic [GIDX_W-1:0] index;
	// dispatcher state
	logic busy;
	// completion and results
	logic done;
	logic found;
	logic [GIDX_W-1:0] foundIndex;
	cacheEntry_t foundEntry;
	logic [SUM_W-1:0] sum;

	modport host (output start, op, length, selector, index,
		input busy, done, found, foundIndex, foundEntry, sum);
	modport dispatcher (input start, op, length, selector, index, done, output busy);
	modport collector (input start, op, output done, found, foundIndex, foundEntry, sum);
endinterface

`default_nettype wire

//--- freeCache/freeBank.sv
`timescale 1ns/1ps
`default_nettype none

module freeBank import allocPkg::*; #(
	parameter int BANK_ID = 0,
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
) (
	input wire logic CLK,
	input wire logic RESETn,
	scanIf.bank scan,
	bankHitIf.source hitOut
);

	localparam int IDX_W = $clog2(BANK_DEPTH);
	localparam int BANK_W = $clog2(NUM_BANKS);

	// bank storage, synchronous read
	cacheEntry_t mem [BANK_DEPTH];

	cacheEntry_t rdEntry;
	logic [IDX_W-1:0] rdIndex;
	logic rdValid;
	logic wrSel;
	logic match;

	// clear hits every bank, single writes only the addressed one
	assign wrSel = scan.wrEn && ((scan.op == OP_CLEAR) || (scan.wrBank == BANK_W'(BANK_ID)));

	// ----------------------------------------------------------------------
	// RAM port
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (wrSel) begin
			mem[scan.stepIndex] <= scan.wrData;
		end
		rdEntry <= mem[scan.stepIndex];
		rdIndex <= scan.stepIndex;
	end

	// match rule per operation
	always_comb begin
		case (scan.op)
			OP_FIND_FREE: match = (rdEntry.selector == '0);
			OP_FIND_FIT: begin
				match = (rdEntry.selector != '0) && (rdEntry.length >= scan.reqLength);
			end
			OP_CALC: match = (rdEntry.selector != '0);
			default: match = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// valid pipe, read stage then compare stage
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			rdValid <= 1'b0;
			hitOut.hitValid <= 1'b0;
		end else begin
			rdValid <= scan.stepValid;
			hitOut.hitValid <= rdValid;
		end
	end

	// compare register
	always_ff @(posedge CLK) begin
		hitOut.hit <= match;
		hitOut.hitIndex <= rdIndex;
		hitOut.entry <= rdEntry;
	end

	// a scan step never shares a cycle with a single write
	noWriteDuringScan: assert property (@(posedge CLK) disable iff (!RESETn)
		!(scan.wrEn && scan.stepValid && (scan.op != OP_CLEAR)));

endmodule

`default_nettype wire

//--- freeCache/scanDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module scanDispatch import allocPkg::*; #(
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
) (
	input wire logic CLK,
	input wire logic RESETn,
	resultIf.dispatcher res,
	scanIf.master scan
);

	localparam int IDX_W = $clog2(BANK_DEPTH);
	localparam int BANK_W = $clog2(NUM_BANKS);

	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		SCAN,
		DRAIN
	} dispState_t;

	dispState_t state;
	logic lastStep;
	logic scanEnd;
	logic accept;

	assign accept = (state == IDLE) && res.start;
	assign lastStep = (scan.stepIndex == IDX_W'(BANK_DEPTH - 1));
	// find hit or table end
	assign scanEnd = scan.stop || lastStep;

	// ----------------------------------------------------------------------
	// operation FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= IDLE;
			res.busy <= 1'b0;
			scan.stepValid <= 1'b0;
			scan.wrEn <= 1'b0;
			scan.op <= OP_WRITE;
		end else begin
			case (state)
				IDLE: begin
					if (res.start) begin
						res.busy <= 1'b1;
						scan.op <= res.op;
						if (res.op == OP_WRITE) begin
							state <= WRITE;
							scan.wrEn <= 1'b1;
						end else begin
							state <= SCAN;
							scan.stepValid <= 1'b1;
							// clear sweep writes at every step
							scan.wrEn <= (res.op == OP_CLEAR);
						end
					end
				end
				WRITE: begin
					scan.wrEn <= 1'b0;
					state <= DRAIN;
				end
				SCAN: begin
					if (scanEnd) begin
						scan.stepValid <= 1'b0;
						scan.wrEn <= 1'b0;
						state <= DRAIN;
					end
				end
				DRAIN: begin
					// banks still flushing, wait for collector
					if (res.done) begin
						res.busy <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// step index and write payload
	always_ff @(posedge CLK) begin
		if (accept) begin
			scan.reqLength <= res.length;
			if (res.op == OP_WRITE) begin
				// global index to bank and local slot
				scan.wrBank <= BANK_W'(res.index % NUM_BANKS);
				scan.stepIndex <= IDX_W'(res.index / NUM_BANKS);
				scan.wrData.selector <= res.selector;
				scan.wrData.length <= res.length;
			end else begin
				scan.wrBank <= '0;
				scan.stepIndex <= '0;
				scan.wrData <= '0;
			end
		end else if ((state == SCAN) && !scanEnd) begin
			scan.stepIndex <= scan.stepIndex + 1'b1;
		end
	end

	// host never issues over a running operation
	noStartWhileBusy: assert property (@(posedge CLK) disable iff (!RESETn)
		res.start |-> !res.busy);

endmodule

`default_nettype wire

//--- freeCache/hitCollector.sv
`timescale 1ns/1ps
`default_nettype none

module hitCollector import allocPkg::*; #(
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
) (
	input wire logic CLK,
	input wire logic RESETn,
	bankHitIf.sink hits [NUM_BANKS],
	scanIf.collector scan,
	resultIf.collector res
);

	localparam int IDX_W = $clog2(BANK_DEPTH);
	localparam int BANK_W = $clog2(NUM_BANKS);
	localparam int GIDX_W = $clog2(NUM_BANKS * BANK_DEPTH);

	logic [NUM_BANKS-1:0] hitVec;
	logic [NUM_BANKS-1:0] lastVec;
	logic [IDX_W-1:0] hitIdx [NUM_BANKS];
	cacheEntry_t hitEntry [NUM_BANKS];

	logic active;
	cacheOp_t curOp;
	logic isFind;
	logic [BANK_W-1:0] firstBank;
	logic [SUM_W-1:0] stepSum;
	logic [GIDX_W-1:0] firstIndex;

	// flatten the bank channels
	for (genvar b = 0; b < NUM_BANKS; b++) begin : gUnpack
		assign hitVec[b] = hits[b].hitValid && hits[b].hit;
		assign lastVec[b] = hits[b].hitValid && (hits[b].hitIndex == IDX_W'(BANK_DEPTH - 1));
		assign hitIdx[b] = hits[b].hitIndex;
		assign hitEntry[b] = hits[b].entry;
	end

	// ----------------------------------------------------------------------
	// per-step merge
	// ----------------------------------------------------------------------
	always_comb begin
		firstBank = '0;
		stepSum = '0;
		// downward walk so the lowest bank wins
		for (int b = NUM_BANKS - 1; b >= 0; b--) begin
			if (hitVec[b]) begin
				firstBank = BANK_W'(b);
			end
		end
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (hitVec[b]) begin
				stepSum = stepSum + SUM_W'(hitEntry[b].length);
			end
		end
	end

	// interleaved layout, local times banks plus bank
	assign firstIndex = GIDX_W'(hitIdx[firstBank]) * GIDX_W'(NUM_BANKS) + GIDX_W'(firstBank);
	assign isFind = (curOp == OP_FIND_FREE) || (curOp == OP_FIND_FIT);
	// earliest step with a hit ends the find
	assign scan.stop = active && isFind && (|hitVec);

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			active <= 1'b0;
			curOp <= OP_WRITE;
			res.done <= 1'b0;
			res.found <= 1'b0;
			res.sum <= '0;
		end else begin
			res.done <= 1'b0;
			if (res.start) begin
				active <= 1'b1;
				curOp <= res.op;
				res.found <= 1'b0;
				if (res.op == OP_CALC) begin
					res.sum <= '0;
				end
			end else if (active) begin
				if (curOp == OP_WRITE) begin
					// single write lands this cycle
					if (scan.wrEn) begin
						res.done <= 1'b1;
						active <= 1'b0;
					end
				end else if (scan.stop) begin
					res.found <= 1'b1;
					res.done <= 1'b1;
					active <= 1'b0;
				end else begin
					if (curOp == OP_CALC) begin
						res.sum <= res.sum + stepSum;
					end
					// last local index reached, nothing found
					if (|lastVec) begin
						res.done <= 1'b1;
						active <= 1'b0;
					end
				end
			end
		end
	end

	// winning entry, late steps dropped once inactive
	always_ff @(posedge CLK) begin
		if (scan.stop) begin
			res.foundIndex <= firstIndex;
			res.foundEntry <= hitEntry[firstBank];
		end
	end

endmodule

`default_nettype wire

//--- hdl/wbRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module wbRegFile import allocPkg::*; #(
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
) (
	input wire logic CLK,
	input wire logic RESETn,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [2:0] wbAdr,
	input wire logic [31:0] wbDatW,
	output logic [31:0] wbDatR,
	output logic wbAck,
	resultIf.host res
);

	localparam int GIDX_W = $clog2(NUM_BANKS * BANK_DEPTH);

	regAddr_t addr;
	logic req;
	logic cmdWrite;
	logic cmdStall;
	logic [31:0] rdMux;
	logic [31:0] status;
	// results captured at the end of each operation
	logic foundReg;
	logic [GIDX_W-1:0] foundIndexReg;
	cacheEntry_t foundEntryReg;
	logic [31:0] cachedSumReg;

	assign addr = regAddr_t'(wbAdr);
	// new access, ack cycle of the previous one excluded
	assign req = wbCyc && wbStb && !wbAck;
	assign cmdWrite = req && wbWe && (addr == REG_COMMAND);
	// only back-pressure in the design
	assign cmdStall = cmdWrite && res.busy;

	// ----------------------------------------------------------------------
	// handshake and control
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			wbAck <= 1'b0;
			res.start <= 1'b0;
			foundReg <= 1'b0;
		end else begin
			wbAck <= req && !cmdStall;
			// single pulse, issued with the ack
			res.start <= cmdWrite && !res.busy;
			if (res.done) begin
				foundReg <= res.found;
			end
		end
	end

	// request registers and result capture
	always_ff @(posedge CLK) begin
		if (req && wbWe) begin
			case (addr)
				REG_LENGTH: res.length <= wbDatW;
				REG_SELECTOR: res.selector <= wbDatW[SEL_W-1:0];
				REG_INDEX: res.index <= wbDatW[GIDX_W-1:0];
				REG_COMMAND: begin
					// held off until busy drops
					if (!res.busy) begin
						res.op <= cacheOp_t'(wbDatW[$bits(cacheOp_t)-1:0]);
					end
				end
				default: ;
			endcase
		end
		if (res.done) begin
			foundIndexReg <= res.foundIndex;
			foundEntryReg <= res.foundEntry;
			// host sees the low word only
			cachedSumReg <= res.sum[31:0];
		end
		if (req && !wbWe) begin
			wbDatR <= rdMux;
		end
	end

	// ----------------------------------------------------------------------
	// read multiplexer
	// ----------------------------------------------------------------------
	always_comb begin
		status = '0;
		status[STATUS_BUSY_BIT] = res.busy;
		status[STATUS_FOUND_BIT] = foundReg;
		case (addr)
			REG_LENGTH: rdMux = res.length;
			REG_SELECTOR: rdMux = 32'(res.selector);
			REG_INDEX: rdMux = 32'(res.index);
			REG_COMMAND: rdMux = status;
			REG_FOUND_LENGTH: rdMux = foundEntryReg.length;
			REG_FOUND_SELECTOR: rdMux = 32'(foundEntryReg.selector);
			REG_FOUND_INDEX: rdMux = 32'(foundIndexReg);
			REG_CACHED_SUM: rdMux = cachedSumReg;
			default: rdMux = '0;
		endcase
	end

	// ack only ever answers a request seen the cycle before
	ackFollowsReq: assert property (@(posedge CLK) disable iff (!RESETn)
		$rose(wbAck) |-> $past(wbCyc && wbStb));

endmodule

`default_nettype wire

//--- hdl/ctxAllocCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module ctxAllocCtrl import allocPkg::*; #(
	parameter int NUM_BANKS = NUM_BANKS_DEFAULT,
	parameter int BANK_DEPTH = BANK_DEPTH_DEFAULT
) (
	input wire logic CLK,
	input wire logic RESETn,
	// wishbone classic slave
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [2:0] wbAdr,
	input wire logic [31:0] wbDatW,
	output logic [31:0] wbDatR,
	output logic wbAck
);

	// ----------------------------------------------------------------------
	// internal buses
	// ----------------------------------------------------------------------
	resultIf #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) res ();
	scanIf #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) scan ();
	// one result channel per bank
	bankHitIf #(.BANK_DEPTH(BANK_DEPTH)) bankHit [NUM_BANKS] ();

	// host register file, the only source of commands
	wbRegFile #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) wbRegFile_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.res(res.host)
	);

	// operation sequencer
	scanDispatch #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) scanDispatch_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.res(res.dispatcher),
		.scan(scan.master)
	);

	// interleaved banks, all fed the same step
	for (genvar b = 0; b < NUM_BANKS; b++) begin : gBank
		freeBank #(
			.BANK_ID(b),
			.NUM_BANKS(NUM_BANKS),
			.BANK_DEPTH(BANK_DEPTH)
		) freeBank_inst (
			.CLK(CLK),
			.RESETn(RESETn),
			.scan(scan.bank),
			.hitOut(bankHit[b].source)
		);
	end

	// merges bank results, ends the scan
	hitCollector #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) hitCollector_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.hits(bankHit),
		.scan(scan.collector),
		.res(res.collector)
	);

endmodule

`default_nettype wire

//--- test/tbWbTasks.svh
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// ----------------------------------------------------------------------
// wishbone classic master
// ----------------------------------------------------------------------

// one access held until ack, waited counts the clocks spent
task automatic wbAccess(input logic we, input logic [2:0] adr, input logic [31:0] datW,
		output logic [31:0] datR, output int waited);
	int cycles;
	cycles = 0;
	@(posedge CLK);
	#DRIVE_DLY;
	wbCyc = 1'b1;
	wbStb = 1'b1;
	wbWe = we;
	wbAdr = adr;
	wbDatW = datW;
	// command writes stall here while the cache is busy
	do begin
		@(posedge CLK);
		#DRIVE_DLY;
		cycles++;
		if (cycles > ACK_TIMEOUT) begin
			abortRun($sformatf("no wishbone ack at address %0d after %0d cycles", adr, cycles));
		end
	end while (!wbAck);
	datR = wbDatR;
	// stb drops right after the ack cycle
	wbCyc = 1'b0;
	wbStb = 1'b0;
	wbWe = 1'b0;
	waited = cycles;
endtask

task automatic writeReg(input regAddr_t adr, input logic [31:0] data);
	logic [31:0] discard;
	int waited;
	wbAccess(1'b1, adr, data, discard, waited);
endtask

task automatic readReg(input regAddr_t adr, output logic [31:0] data);
	int waited;
	wbAccess(1'b0, adr, 32'h0, data, waited);
endtask

// status poll, returns once busy is low
task automatic waitIdle();
	logic [31:0] status;
	int polls;
	polls = 0;
	do begin
		readReg(REG_COMMAND, status);
		polls++;
		if (polls > POLL_TIMEOUT) begin
			abortRun($sformatf("cache still busy after %0d status polls", polls));
		end
	end while (status[STATUS_BUSY_BIT]);
endtask

// issue one operation and wait for its end
task automatic runCommand(input cacheOp_t op);
	writeReg(REG_COMMAND, 32'(op));
	waitIdle();
endtask

`endif

//--- test/tbCtxAlloc.sv
`timescale 1ns/1ps
`default_nettype none

module tbCtxAlloc import allocPkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 5;
	localparam int RESET_CYCLES = 8;
	localparam logic [15:0] SEED = 16'd55185;
	// limits in clocks per access and in polls per operation
	localparam int ACK_TIMEOUT = 64;
	localparam int POLL_TIMEOUT = 40;
	localparam int TABLE_SIZE = NUM_BANKS_DEFAULT * BANK_DEPTH_DEFAULT;
	localparam int IDX_BITS = $clog2(TABLE_SIZE);

	logic CLK;
	logic RESETn;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [2:0] wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic wbAck;

	logic [15:0] lfsrState;
	int errorCount;
	int checkCount;
	// reference table by global index
	logic [SEL_W-1:0] modelSel [TABLE_SIZE];
	logic [LEN_W-1:0] modelLen [TABLE_SIZE];

	ctxAllocCtrl ctxAllocCtrl_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) CLK = ~CLK;
		end
	end

	`include "tbWbTasks.svh"

	// ----------------------------------------------------------------------
	// random source and reference model
	// ----------------------------------------------------------------------
	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// lowest in-use slot long enough for req when fit is set
	// lowest free slot otherwise
	function automatic int lowestMatch(input logic fit, input logic [LEN_W-1:0] req);
		for (int i = 0; i < TABLE_SIZE; i++) begin
			if (fit && (modelSel[i] != '0) && (modelLen[i] >= req)) begin
				return i;
			end
			if (!fit && (modelSel[i] == '0)) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic logic [SUM_W-1:0] inUseSum();
		logic [SUM_W-1:0] s;
		s = '0;
		for (int i = 0; i < TABLE_SIZE; i++) begin
			if (modelSel[i] != '0) begin
				s = s + SUM_W'(modelLen[i]);
			end
		end
		return s;
	endfunction

	// ----------------------------------------------------------------------
	// checks and reporting
	// ----------------------------------------------------------------------
	task automatic abortRun(input string reason);
		errorCount++;
		$display("%0t: %s", $time, reason);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		$display("Verification failed");
		$finish;
	endtask

	task automatic compareValue(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// found flag plus index and entry when a hit is expected
	task automatic confirmFind(input string what, input int expIdx);
		logic [31:0] rd;
		readReg(REG_COMMAND, rd);
		compareValue({what, " found flag"}, 32'(rd[STATUS_FOUND_BIT]), 32'(expIdx >= 0));
		if (expIdx >= 0) begin
			readReg(REG_FOUND_INDEX, rd);
			compareValue({what, " index"}, rd, 32'(expIdx));
			readReg(REG_FOUND_LENGTH, rd);
			compareValue({what, " length"}, rd, modelLen[expIdx]);
			readReg(REG_FOUND_SELECTOR, rd);
			compareValue({what, " selector"}, rd, 32'(modelSel[expIdx]));
		end
	endtask

	task automatic auditSum(input string what);
		logic [31:0] rd;
		runCommand(OP_CALC);
		readReg(REG_CACHED_SUM, rd);
		compareValue(what, rd, 32'(inUseSum()));
	endtask

	task automatic storeEntry(input int idx, input logic [SEL_W-1:0] sel,
			input logic [LEN_W-1:0] len);
		writeReg(REG_LENGTH, len);
		writeReg(REG_SELECTOR, 32'(sel));
		writeReg(REG_INDEX, 32'(idx));
		runCommand(OP_WRITE);
		modelSel[idx] = sel;
		modelLen[idx] = len;
	endtask

	task automatic resetTable();
		runCommand(OP_CLEAR);
		for (int i = 0; i < TABLE_SIZE; i++) begin
			modelSel[i] = '0;
			modelLen[i] = '0;
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin
		int idx;
		int waited;
		logic [SEL_W-1:0] sel;
		logic [LEN_W-1:0] len;
		logic [LEN_W-1:0] req;
		logic [31:0] rd;
		errorCount = 0;
		checkCount = 0;
		lfsrState = SEED;
		RESETn = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DLY;
		RESETn = 1'b1;

		// idle after reset then clear and first free slot
		readReg(REG_COMMAND, rd);
		compareValue("status after reset", rd & 32'h3, 32'h0);
		resetTable();
		runCommand(OP_FIND_FREE);
		confirmFind("free search after clear", 0);

		// random writes each followed by a fit search
		for (int n = 0; n < 24; n++) begin
			idx = int'(randBits(IDX_BITS));
			sel = SEL_W'(randBits(SEL_W));
			len = randBits(LEN_W);
			storeEntry(idx, sel, len);
			req = randBits(LEN_W);
			// about half the searches ask for no more than the new length
			if (randBits(1) == 32'd1) begin
				req = len >> randBits(3);
			end
			writeReg(REG_LENGTH, req);
			runCommand(OP_FIND_FIT);
			confirmFind("fit search", lowestMatch(1'b1, req));
		end
		auditSum("sum of sparse table");

		// free search while the table fills up
		for (int n = 0; n < 10; n++) begin
			repeat (3) begin
				idx = int'(randBits(IDX_BITS));
				sel = SEL_W'(randBits(SEL_W)) | SEL_W'(1);
				len = randBits(LEN_W);
				storeEntry(idx, sel, len);
			end
			runCommand(OP_FIND_FREE);
			confirmFind("free search", lowestMatch(1'b0, '0));
		end
		for (int i = 0; i < TABLE_SIZE; i++) begin
			if (modelSel[i] == '0) begin
				sel = SEL_W'(randBits(SEL_W)) | SEL_W'(1);
				len = randBits(LEN_W);
				storeEntry(i, sel, len);
			end
		end
		runCommand(OP_FIND_FREE);
		confirmFind("free search on full table", -1);
		auditSum("sum of full table");

		// new length in one slot so the next sum differs from the cached one
		idx = int'(randBits(IDX_BITS));
		sel = SEL_W'(randBits(SEL_W)) | SEL_W'(1);
		len = randBits(LEN_W);
		storeEntry(idx, sel, len);

		// command over a running CALC while reads still answer at once
		len = randBits(LEN_W);
		writeReg(REG_LENGTH, len);
		writeReg(REG_COMMAND, 32'(OP_CALC));
		readReg(REG_COMMAND, rd);
		compareValue("busy after command ack", 32'(rd[STATUS_BUSY_BIT]), 32'd1);
		readReg(REG_LENGTH, rd);
		compareValue("length read while busy", rd, len);
		wbAccess(1'b1, REG_COMMAND, 32'(OP_FIND_FREE), rd, waited);
		checkCount++;
		if (waited < 3) begin
			errorCount++;
			$display("[ERROR] %0t: command over busy cache acked after %0d cycles",
				$time, waited);
		end
		readReg(REG_CACHED_SUM, rd);
		compareValue("sum before stalled command", rd, 32'(inUseSum()));
		waitIdle();
		confirmFind("free search after stall", lowestMatch(1'b0, '0));

		resetTable();
		auditSum("sum after final clear");

		repeat (2) @(posedge CLK);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+test
common/allocPkg.sv
common/cacheIfs.sv
freeCache/freeBank.sv
freeCache/scanDispatch.sv
freeCache/hitCollector.sv
hdl/wbRegFile.sv
hdl/ctxAllocCtrl.sv
test/tbCtxAlloc.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the free-object cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG" build.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tbCtxAlloc \
	-o simCtxAlloc > build.log 2>&1 \
	&& ./obj_dir/simCtxAlloc > "$LOG" 2>&1 \
	|| { cat build.log "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
# the verdict comes from the simulation log
grep -q "Verification failed" "$LOG" && exit 1
grep -q "Verification passed" "$LOG" || exit 1
exit 0
